//--- hdl/scrypt_types_pkg.sv
// Fixed to scrypt with r = 1 and a full scratchpad of N = 1024 blocks
// Words are little-endian 32-bit Salsa words, word 0 in the lowest bits
`default_nettype none

package scrypt_types_pkg;

	localparam int WORD_BITS = 32;
	localparam int STATE_WORDS = 16;	// Words in one Salsa20/8 state

	// Full scrypt block is two Salsa states, 1024 bits for r = 1
	localparam int BLOCK_BITS = 2 * STATE_WORDS * WORD_BITS;

	localparam int SCRYPT_N = 1024;	// Scratchpad entries, one block each
	localparam int SCRATCH_ADDR_BITS = $clog2(SCRYPT_N);

	// Integerify looks at the first word of the high half of X
	localparam int INTEGERIFY_WORD = STATE_WORDS;

	typedef logic [WORD_BITS-1:0] word_t;

	// Packed so that word i sits at bits 32i+31 down to 32i
	typedef word_t [STATE_WORDS-1:0] salsa_state_t;

	// Index 0 is the low half B0, index 1 the high half B1
	typedef salsa_state_t [1:0] block_t;

	typedef logic [SCRATCH_ADDR_BITS-1:0] scratch_addr_t;

endpackage

`default_nettype wire

//--- hdl/romix_ctl_pkg.sv
// Control encodings for the single-thread ROMix sequencer and its Salsa20/8 core
`default_nettype none

package romix_ctl_pkg;

	// Idle waits for start, fill writes the scratchpad, mix reads it back
	typedef enum logic [1:0]
	{
		ST_IDLE,
		ST_FILL,
		ST_MIX
	} romix_state_e;

	// A BlockMix is two Salsa passes run one after the other
	typedef enum logic
	{
		HALF_FIRST,	// Y0 from B1 xor B0
		HALF_SECOND	// Y1 from Y0 xor B1
	} blockmix_half_e;

	// Salsa20/8 is eight rounds, done as four double rounds, one per cycle
	localparam int SALSA_DOUBLE_ROUNDS = 4;

	// Round counter runs 1 up to SALSA_DOUBLE_ROUNDS inclusive
	localparam int ROUND_CNT_BITS = $clog2(SALSA_DOUBLE_ROUNDS + 1);

endpackage

`default_nettype wire

//--- hdl/block_shift_reg.sv
// Serial load and unload of one 1024-bit block, first bit in becomes the block MSB
// Contents are undefined until a full block has been shifted in or a result loaded
`timescale 1ns/1ns
`default_nettype none

module block_shift_reg
	import scrypt_types_pkg::*;
(
	input  logic   hash_clk,
	input  logic   shift,
	input  logic   din,
	output logic   dout,
	input  logic   load,
	input  block_t block_out,
	output block_t block_in
);

	logic [BLOCK_BITS-1:0] shift_q;	// Wire-order contents

	// Byte-swap every 32-bit slice, the same swap works in both directions
	function automatic logic [BLOCK_BITS-1:0] swap_words(logic [BLOCK_BITS-1:0] v);
		logic [BLOCK_BITS-1:0] r;
		word_t w;
		for (int i = 0; i < BLOCK_BITS / WORD_BITS; i++)
		begin
			w = v[i*WORD_BITS +: WORD_BITS];
			r[i*WORD_BITS +: WORD_BITS] = {w[7:0], w[15:8], w[23:16], w[31:24]};
		end
		return r;
	endfunction

	always_ff @(posedge hash_clk)
	begin
		if (shift)
			shift_q <= {shift_q[BLOCK_BITS-2:0], din};	// New bit enters at the LSB
		else if (load)
			shift_q <= swap_words(block_out);	// Result goes back out in wire order
	end

	assign dout = shift_q[BLOCK_BITS-1];	// Oldest bit leaves first
	assign block_in = swap_words(shift_q);	// Little-endian words for the sequencer

	// The load comes from the sequencer at the end of a run while shifting is host paced,
	// if both land together the result would be lost
	a_no_shift_on_load: assert property (@(posedge hash_clk) !(shift && load))
		else $error("shift and load high on the same cycle");

endmodule

`default_nettype wire

//--- hdl/salsa20_8_core.sv
// Iterative Salsa20/8, one double round per cycle, result with out_valid 4 cycles after in_valid
// A new in_valid is only taken once the previous pass has finished
`timescale 1ns/1ns
`default_nettype none

module salsa20_8_core
	import scrypt_types_pkg::*;
	import romix_ctl_pkg::*;
(
	input  logic         hash_clk,
	input  logic         fsmreset,
	input  logic         in_valid,
	input  salsa_state_t state_in,
	output salsa_state_t state_out,
	output logic         out_valid
);

	logic                      running;
	logic [ROUND_CNT_BITS-1:0] rounds;	// Double rounds completed so far
	salsa_state_t              work;	// State being mixed
	salsa_state_t              copy;	// Input kept for the feed-forward add
	salsa_state_t              round_in;
	logic                      last_round;

	function automatic word_t rotl(word_t v, int n);
		return (v << n) | (v >> (WORD_BITS - n));
	endfunction

	// Standard Salsa quarter round on words a, b, c, d of the state
	function automatic salsa_state_t quarter_round(salsa_state_t s, int a, int b, int c, int d);
		salsa_state_t t;
		t = s;
		t[b] = t[b] ^ rotl(t[a] + t[d], 7);
		t[c] = t[c] ^ rotl(t[b] + t[a], 9);
		t[d] = t[d] ^ rotl(t[c] + t[b], 13);
		t[a] = t[a] ^ rotl(t[d] + t[c], 18);
		return t;
	endfunction

	// Column round followed by row round
	function automatic salsa_state_t double_round(salsa_state_t s);
		salsa_state_t t;
		t = quarter_round(s, 0, 4, 8, 12);
		t = quarter_round(t, 5, 9, 13, 1);
		t = quarter_round(t, 10, 14, 2, 6);
		t = quarter_round(t, 15, 3, 7, 11);
		t = quarter_round(t, 0, 1, 2, 3);	// Rows from here on
		t = quarter_round(t, 5, 6, 7, 4);
		t = quarter_round(t, 10, 11, 8, 9);
		t = quarter_round(t, 15, 12, 13, 14);
		return t;
	endfunction

	assign last_round = running && (rounds == ROUND_CNT_BITS'(SALSA_DOUBLE_ROUNDS));

	// The first double round runs straight off the input, so only one round is instantiated
	assign round_in = in_valid ? state_in : work;

	always_ff @(posedge hash_clk)
	begin
		if (fsmreset)
		begin
			running <= 1'b0;
			rounds <= '0;
		end
		else if (in_valid)
		begin
			running <= 1'b1;
			rounds <= ROUND_CNT_BITS'(1);	// First round done on this edge
		end
		else if (last_round)
			running <= 1'b0;	// Result is shown for this one cycle only
		else if (running)
			rounds <= rounds + 1'b1;
	end

	always_ff @(posedge hash_clk)
	begin
		if (in_valid)
			copy <= state_in;
		if (in_valid || (running && !last_round))
			work <= double_round(round_in);	// Holds once all rounds are in
	end

	// Feed-forward add of the original input, word by word mod 2^32
	always_comb
	begin
		for (int i = 0; i < STATE_WORDS; i++)
			state_out[i] = work[i] + copy[i];
	end

	assign out_valid = last_round;

	// The sequencer must wait for out_valid before launching the next pass
	a_idle_on_start: assert property (@(posedge hash_clk) disable iff (fsmreset)
		in_valid |-> !running)
		else $error("Salsa core started while a pass is still running");

endmodule

`default_nettype wire

//--- hdl/scratchpad_ram.sv
// Full scratchpad, SCRYPT_N blocks of 1024 bits, one write and one read port on hash_clk
// Registered read, a read of the address being written returns the old block
`timescale 1ns/1ns
`default_nettype none

module scratchpad_ram
	import scrypt_types_pkg::*;
(
	input  logic          hash_clk,
	input  logic          wr_en,
	input  scratch_addr_t wr_addr,
	input  block_t        wr_data,
	input  scratch_addr_t rd_addr,
	output block_t        rd_data
);

	block_t mem [SCRYPT_N];	// Contents are undefined until the fill phase writes them

	always_ff @(posedge hash_clk)
	begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
		rd_data <= mem[rd_addr];	// Reads every cycle, the sequencer picks the cycle it needs
	end

endmodule

`default_nettype wire

//--- hdl/romix_sequencer.sv
// ROMix fill and mix control for one thread, X is held here and both BlockMix halves use X0 xor X1
// start is only taken in idle with busy low, result holds until the next accepted start
`timescale 1ns/1ns
`default_nettype none

module romix_sequencer
	import scrypt_types_pkg::*;
	import romix_ctl_pkg::*;
(
	input  logic          hash_clk,
	input  logic          fsmreset,
	input  logic          start,
	input  block_t        block_in,
	output logic          busy,
	output logic          result,
	output logic          load,
	output block_t        block_out,
	output logic          core_valid,
	output salsa_state_t  core_in,
	input  salsa_state_t  core_out,
	input  logic          core_done,
	output logic          wr_en,
	output scratch_addr_t wr_addr,
	output block_t        wr_data,
	output scratch_addr_t rd_addr,
	input  block_t        rd_data
);

	romix_state_e   state;
	blockmix_half_e half;
	scratch_addr_t  iter;	// Fill entry or mix step, wraps from 1023 back to 0
	block_t         x;	// Current X as (X0, X1)
	logic           rd_wait;	// Scratchpad is reading the Integerify entry
	logic           xor_now;	// rd_data holds that entry this cycle
	logic           accept;
	logic           step_done;
	logic           last_iter;

	assign accept = start && !busy && (state == ST_IDLE);
	assign step_done = core_done && (half == HALF_SECOND);	// Whole BlockMix finished
	assign last_iter = (iter == scratch_addr_t'(SCRYPT_N - 1));

	always_ff @(posedge hash_clk)
	begin
		if (fsmreset)
		begin
			state <= ST_IDLE;
			half <= HALF_FIRST;
			iter <= '0;
			busy <= 1'b0;
			result <= 1'b0;
			load <= 1'b0;
			core_valid <= 1'b0;
			wr_en <= 1'b0;
			rd_wait <= 1'b0;
			xor_now <= 1'b0;
		end
		else
		begin
			core_valid <= 1'b0;	// Pulses unless set below
			wr_en <= 1'b0;
			load <= 1'b0;
			rd_wait <= 1'b0;
			xor_now <= rd_wait;	// One cycle of RAM read latency

			// Flags change on the edge that puts the result into the shift register
			if (load)
			begin
				busy <= 1'b0;
				result <= 1'b1;
			end

			if (accept)
			begin
				state <= ST_FILL;
				iter <= '0;
				half <= HALF_FIRST;
				busy <= 1'b1;
				result <= 1'b0;
				core_valid <= 1'b1;	// Entry 0 is written while the first pass starts
				wr_en <= 1'b1;
			end

			if (xor_now)
				core_valid <= 1'b1;	// Mix step starts once the entry is folded in

			if (core_done && half == HALF_FIRST)
			begin
				half <= HALF_SECOND;
				core_valid <= 1'b1;	// Y0 is in X0 now, so X0 xor X1 is Y0 xor B1
			end

			if (step_done)
			begin
				half <= HALF_FIRST;
				iter <= iter + 1'b1;
				case (state)
					ST_FILL:
					begin
						if (last_iter)
						begin
							state <= ST_MIX;	// iter wraps to 0 for the mix count
							rd_wait <= 1'b1;
						end
						else
						begin
							core_valid <= 1'b1;
							wr_en <= 1'b1;	// Store the new X before mixing it
						end
					end
					ST_MIX:
					begin
						if (last_iter)
						begin
							state <= ST_IDLE;
							load <= 1'b1;	// Final X goes to the shift register
						end
						else
							rd_wait <= 1'b1;
					end
					default:
						state <= ST_IDLE;
				endcase
			end
		end
	end

	// X takes block_in on start, then each Salsa result and the scratchpad entry
	always_ff @(posedge hash_clk)
	begin
		if (accept)
			x <= block_in;
		else if (core_done)
		begin
			if (half == HALF_FIRST)
				x[0] <= core_out;
			else
				x[1] <= core_out;
		end
		else if (xor_now)
			x <= x ^ rd_data;	// X xor V[j]
	end

	assign core_in = x[0] ^ x[1];	// Same form for both halves
	assign wr_addr = iter;
	assign wr_data = x;
	// Integerify, low bits of word 16 of the current X
	assign rd_addr = x[INTEGERIFY_WORD / STATE_WORDS][INTEGERIFY_WORD % STATE_WORDS]
		[SCRATCH_ADDR_BITS-1:0];
	assign block_out = x;

	// A run only begins from a start that arrived while the engine was free
	a_start_when_free: assert property (@(posedge hash_clk) disable iff (fsmreset)
		$rose(state == ST_FILL) |-> $past(start && !busy))
		else $error("Run started from a start given while busy");

endmodule

`default_nettype wire

//--- hdl/salsa_engine_top.sv
// Single-thread scrypt ROMix engine, the host shifts a block in, pulses start and waits for result
// fsmreset and start must already be in the hash_clk domain, shift is not allowed while busy
`timescale 1ns/1ns
`default_nettype none

module salsa_engine_top
	import scrypt_types_pkg::*;
(
	input  logic hash_clk,
	input  logic fsmreset,
	input  logic din,
	input  logic shift,
	input  logic start,
	output logic dout,
	output logic busy,
	output logic result
);

	block_t        block_in;	// Host block as little-endian words
	block_t        block_out;	// Final X back to the shift register
	logic          load;
	logic          core_valid;
	salsa_state_t  core_in;
	salsa_state_t  core_out;
	logic          core_done;
	logic          wr_en;
	scratch_addr_t wr_addr;
	block_t        wr_data;
	scratch_addr_t rd_addr;
	block_t        rd_data;

	block_shift_reg i_shift_reg (
		.hash_clk  (hash_clk),
		.shift     (shift),
		.din       (din),
		.dout      (dout),
		.load      (load),
		.block_out (block_out),
		.block_in  (block_in)
	);

	romix_sequencer i_sequencer (
		.hash_clk   (hash_clk),
		.fsmreset   (fsmreset),
		.start      (start),
		.block_in   (block_in),
		.busy       (busy),
		.result     (result),
		.load       (load),
		.block_out  (block_out),
		.core_valid (core_valid),
		.core_in    (core_in),
		.core_out   (core_out),
		.core_done  (core_done),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.rd_addr    (rd_addr),
		.rd_data    (rd_data)
	);

	salsa20_8_core i_salsa (
		.hash_clk  (hash_clk),
		.fsmreset  (fsmreset),
		.in_valid  (core_valid),
		.state_in  (core_in),
		.state_out (core_out),
		.out_valid (core_done)
	);

	scratchpad_ram i_scratchpad (
		.hash_clk (hash_clk),
		.wr_en    (wr_en),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data),
		.rd_addr  (rd_addr),
		.rd_data  (rd_data)
	);

	// The shift register is the input while a run is going, shifting would corrupt nothing
	// in the core but the final load would collide with host traffic
	a_no_shift_while_busy: assert property (@(posedge hash_clk) disable iff (fsmreset)
		shift |-> !busy)
		else $error("Host shifted while the engine was busy");

endmodule

`default_nettype wire

//--- testbench/tb_scrypt_model.svh
// Behavioural scrypt model for r = 1 and N = SCRYPT_N, meant to be included inside a module body
// The including module must import scrypt_types_pkg first
`ifndef TB_SCRYPT_MODEL_SVH
`define TB_SCRYPT_MODEL_SVH

	block_t pad_ref [SCRYPT_N];	// Model copy of the scratchpad

	// Fibonacci LFSR with taps 32, 22, 2 and 1, maximal length
	function automatic logic [31:0] lfsr_step(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic word_t rol32(word_t v, int n);
		return (v << n) | (v >> (32 - n));
	endfunction

	// One Salsa quarter round, the updated a, b, c, d come back packed in that order
	function automatic logic [127:0] quarter_mix(word_t a, word_t b, word_t c, word_t d);
		b = b ^ rol32(a + d, 7);
		c = c ^ rol32(b + a, 9);
		d = d ^ rol32(c + b, 13);
		a = a ^ rol32(d + c, 18);
		return {a, b, c, d};
	endfunction

	// Salsa20/8 as four passes of a column round and a row round, then the feed-forward add
	function automatic salsa_state_t salsa_8(salsa_state_t s);
		word_t x [16];
		salsa_state_t r;
		for (int i = 0; i < 16; i++)
			x[i] = s[i];
		for (int n = 0; n < 8; n += 2)
		begin
			// Columns
			{x[0], x[4], x[8], x[12]} = quarter_mix(x[0], x[4], x[8], x[12]);
			{x[5], x[9], x[13], x[1]} = quarter_mix(x[5], x[9], x[13], x[1]);
			{x[10], x[14], x[2], x[6]} = quarter_mix(x[10], x[14], x[2], x[6]);
			{x[15], x[3], x[7], x[11]} = quarter_mix(x[15], x[3], x[7], x[11]);
			// Rows
			{x[0], x[1], x[2], x[3]} = quarter_mix(x[0], x[1], x[2], x[3]);
			{x[5], x[6], x[7], x[4]} = quarter_mix(x[5], x[6], x[7], x[4]);
			{x[10], x[11], x[8], x[9]} = quarter_mix(x[10], x[11], x[8], x[9]);
			{x[15], x[12], x[13], x[14]} = quarter_mix(x[15], x[12], x[13], x[14]);
		end
		for (int i = 0; i < 16; i++)
			r[i] = x[i] + s[i];	// Feed-forward, mod 2^32 per word
		return r;
	endfunction

	// BlockMix for r = 1, output is (Y0, Y1) with no shuffle needed
	function automatic block_t mix_block(block_t b);
		block_t r;
		r[0] = salsa_8(b[1] ^ b[0]);
		r[1] = salsa_8(r[0] ^ b[1]);
		return r;
	endfunction

	// Full ROMix, fill the pad then mix with the entry picked by Integerify
	function automatic block_t romix_expected(block_t b);
		block_t x;
		logic [BLOCK_BITS-1:0] flat;
		logic [31:0] w;
		int j;
		x = b;
		for (int i = 0; i < SCRYPT_N; i++)
		begin
			pad_ref[i] = x;
			x = mix_block(x);
		end
		for (int i = 0; i < SCRYPT_N; i++)
		begin
			flat = x;
			w = flat[INTEGERIFY_WORD * WORD_BITS +: 32];	// First word of the high half
			j = w % SCRYPT_N;
			x = mix_block(x ^ pad_ref[j]);
		end
		return x;
	endfunction

`endif

//--- testbench/tb_salsa_engine.sv
// Checks the ROMix engine against the included model on LFSR blocks, each run is about 23k cycles
// Inputs change on the falling edge of hash_clk and outputs are read on that edge as well
`timescale 1ns/1ns
`default_nettype none

module tb_salsa_engine
	import scrypt_types_pkg::*;
	import romix_ctl_pkg::*;
();

	localparam logic [31:0] LFSR_SEED = 32'h3ecf_31ad;
	localparam int RANDOM_RUNS = 3;	// Back-to-back random runs
	localparam int RUN_COUNT = RANDOM_RUNS + 4;	// Plus ignored start, zero block, abort, rerun
	localparam int STEP_CYCLES = 2 * (SALSA_DOUBLE_ROUNDS + 1) + 2;	// Worst BlockMix, a mix step
	localparam int CYCLE_LIMIT = 4 * RUN_COUNT * 2 * SCRYPT_N * STEP_CYCLES;

	logic hash_clk = 1'b0;
	logic fsmreset;
	logic din;
	logic shift;
	logic start;
	logic dout;
	logic busy;
	logic result;

	logic [31:0] lfsr_state;
	block_t expect_blk;	// Model result of the last finished run
	logic have_expect;	// Set once a run finished and its result still sits in the DUT
	int block_checks = 0;
	int flag_checks = 0;
	int block_errors = 0;
	int flag_errors = 0;
	int cycle_count = 0;

	`include "tb_scrypt_model.svh"

	salsa_engine_top i_dut (
		.hash_clk (hash_clk),
		.fsmreset (fsmreset),
		.din      (din),
		.shift    (shift),
		.start    (start),
		.dout     (dout),
		.busy     (busy),
		.result   (result)
	);

	always #5 hash_clk = ~hash_clk;	// 10 ns period

	// Hard stop well past the slowest expected run length
	always @(posedge hash_clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT)
		begin
			$display("Run timed out: the engine did not finish within %0d cycles", CYCLE_LIMIT);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	task automatic compare_block(input block_t got, input block_t exp, input string what);
		logic [BLOCK_BITS-1:0] g;
		logic [BLOCK_BITS-1:0] e;
		int k;
		block_checks++;
		if (got !== exp)
		begin
			g = got;
			e = exp;
			k = 0;
			for (int i = BLOCK_BITS / WORD_BITS - 1; i >= 0; i--)
				if (g[i*WORD_BITS +: WORD_BITS] !== e[i*WORD_BITS +: WORD_BITS])
					k = i;	// Lowest differing word wins
			block_errors++;
			$display("** Error at %0t ns: %s, word %0d is %h, expected %h", $time, what, k,
				g[k*WORD_BITS +: WORD_BITS], e[k*WORD_BITS +: WORD_BITS]);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		flag_checks++;
		if (got !== exp)
		begin
			flag_errors++;
			$display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// Byte n of a word trades places with byte 3 - n between wire order and block layout
	function automatic logic [BLOCK_BITS-1:0] swap_bytes(logic [BLOCK_BITS-1:0] v);
		logic [BLOCK_BITS-1:0] r;
		for (int n = 0; n < BLOCK_BITS / 8; n++)
			r[n*8 +: 8] = v[(n ^ 3)*8 +: 8];
		return r;
	endfunction

	task automatic random_block(output block_t blk);
		logic [BLOCK_BITS-1:0] v;
		for (int i = 0; i < BLOCK_BITS; i++)
		begin
			lfsr_state = lfsr_step(lfsr_state);	// One step per bit
			v[i] = lfsr_state[0];
		end
		blk = v;
	endtask

	// Shifts blk in, the bits pushed out are the previous result when one is pending
	task automatic load_block(input block_t blk);
		logic [BLOCK_BITS-1:0] wire_in;
		logic [BLOCK_BITS-1:0] wire_out;
		wire_in = swap_bytes(blk);
		for (int i = BLOCK_BITS - 1; i >= 0; i--)
		begin
			@(negedge hash_clk);
			wire_out[i] = dout;	// MSB shows before the shifting edge
			din = wire_in[i];
			shift = 1'b1;
			check_flag(busy, 1'b0, "busy while shifting");
		end
		@(negedge hash_clk);
		shift = 1'b0;
		din = 1'b0;
		if (have_expect)
			compare_block(swap_bytes(wire_out), expect_blk, "shifted-out result");
		have_expect = 1'b0;
	endtask

	task automatic pulse_start();
		@(negedge hash_clk);
		start = 1'b1;
		@(negedge hash_clk);
		start = 1'b0;
	endtask

	task automatic start_run(input block_t blk);
		expect_blk = romix_expected(blk);	// Zero sim time, only wall clock
		pulse_start();
		check_flag(busy, 1'b1, "busy after start");
		check_flag(result, 1'b0, "result after start");
	endtask

	// Ends on the first sample where busy dropped or result rose, both must hold there
	task automatic wait_result();
		do
			@(negedge hash_clk);
		while (busy && !result);
		check_flag(busy, 1'b0, "busy at end of run");
		check_flag(result, 1'b1, "result at end of run");
		have_expect = 1'b1;
	endtask

	initial
	begin
		block_t blk;
		fsmreset = 1'b1;
		shift = 1'b0;
		din = 1'b0;
		start = 1'b0;
		lfsr_state = LFSR_SEED;
		have_expect = 1'b0;
		repeat (16) @(negedge hash_clk);
		fsmreset = 1'b0;

		// Flags are quiet out of reset and while a block comes in without start
		check_flag(busy, 1'b0, "busy after reset");
		check_flag(result, 1'b0, "result after reset");
		random_block(blk);
		load_block(blk);
		repeat (8) @(negedge hash_clk);
		check_flag(busy, 1'b0, "busy without start");
		check_flag(result, 1'b0, "result without start");

		// Each unload also loads the next block, so these runs go back to back
		for (int t = 0; t < RANDOM_RUNS; t++)
		begin
			start_run(blk);
			wait_result();
			random_block(blk);
			load_block(blk);
		end

		start_run(blk);	// Second start lands mid-run and must be dropped
		repeat (20) @(negedge hash_clk);
		pulse_start();
		wait_result();
		repeat (50) @(negedge hash_clk);
		check_flag(busy, 1'b0, "busy after ignored start");
		check_flag(result, 1'b1, "result after ignored start");
		load_block('0);

		start_run('0);	// All-zero block reads entry 0 on the first mix step
		wait_result();
		random_block(blk);
		load_block(blk);

		pulse_start();	// Aborted by reset, no result expected
		repeat (600) @(negedge hash_clk);
		fsmreset = 1'b1;
		repeat (4) @(negedge hash_clk);
		fsmreset = 1'b0;
		check_flag(busy, 1'b0, "busy after mid-run reset");
		check_flag(result, 1'b0, "result after mid-run reset");
		random_block(blk);
		load_block(blk);
		start_run(blk);
		wait_result();
		random_block(blk);
		load_block(blk);	// Unloads the last result

		$display("Checks: %0d block, %0d flag; errors: %0d block, %0d flag",
			block_checks, flag_checks, block_errors, flag_errors);
		if (block_errors + flag_errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
+incdir+testbench
hdl/scrypt_types_pkg.sv
hdl/romix_ctl_pkg.sv
hdl/block_shift_reg.sv
hdl/salsa20_8_core.sv
hdl/scratchpad_ram.sv
hdl/romix_sequencer.sv
hdl/salsa_engine_top.sv
testbench/tb_salsa_engine.sv
